// ==== verilog/approxMul_defs.svh ====
`ifndef APPROX_MUL_DEFS_SVH
`define APPROX_MUL_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// operand and result sizes
////////////////////////////////////////////////////////////////////////////

// both operands are unsigned, same width
`define AM_WIDTH 16

// full product width, 2 * AM_WIDTH
`define AM_PROD_W 32

////////////////////////////////////////////////////////////////////////////
// truncation
////////////////////////////////////////////////////////////////////////////

// lowest partial-product column that is kept
`define AM_TRUNC_COL 8

// fixed low-byte compensation for the dropped columns
`define AM_BIAS 6

// kept columns, weights AM_TRUNC_COL up to 2*AM_WIDTH-2
`define AM_NUM_COLS 23

////////////////////////////////////////////////////////////////////////////
// column reduction
////////////////////////////////////////////////////////////////////////////

// tallest column holds AM_WIDTH bits, so a count runs 0..16
`define AM_COUNT_W 5

`endif

// ==== verilog/approxMulPkg.sv ====
`include "approxMul_defs.svh"

package approxMulPkg;

    ////////////////////////////////////////////////////////////////////////////
    // column types shared by the matrix, the counters and the assembler
    ////////////////////////////////////////////////////////////////////////////

    // one column of partial-product bits
    // bit j is the product term taken from row j (b[j]), unused rows are zero
    typedef logic [`AM_WIDTH-1:0] colBits_t;

    // number of ones in one column
    typedef logic [`AM_COUNT_W-1:0] colCount_t;

endpackage

// ==== verilog/ppMatrix.sv ====
`timescale 1ns/1ns

`include "approxMul_defs.svh"

// operand registers and the truncated partial-product matrix
module ppMatrix (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  logic [`AM_WIDTH-1:0]   a,
    input  logic [`AM_WIDTH-1:0]   b,
    output logic                   ppValid,
    output approxMulPkg::colBits_t colBits [`AM_NUM_COLS]
);

    import approxMulPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // input stage
    ////////////////////////////////////////////////////////////////////////////

    logic [`AM_WIDTH-1:0] aReg;
    logic [`AM_WIDTH-1:0] bReg;

    // valid strobe, one per accepted operand pair
    always_ff @(posedge clk) begin
        if (rst) begin
            ppValid <= 1'b0;
        end else begin
            ppValid <= inValid;
        end
    end

    // operands
    always_ff @(posedge clk) begin
        aReg <= a;
        bReg <= b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // column layout
    ////////////////////////////////////////////////////////////////////////////

    // column c holds every a[i] & b[j] with i + j == c + AM_TRUNC_COL
    // row j of the column takes a[weight - j], so the a operand is
    // lined up per column and then masked by the whole b word at once
    for (genvar c = 0; c < `AM_NUM_COLS; c++) begin : gCol
        localparam int Weight = c + `AM_TRUNC_COL;

        colBits_t aAligned;

        for (genvar j = 0; j < `AM_WIDTH; j++) begin : gRow
            if ((Weight - j >= 0) && (Weight - j < `AM_WIDTH)) begin : gKept
                assign aAligned[j] = aReg[Weight - j];
            end else begin : gEmpty
                // no a bit reaches this row at this weight
                assign aAligned[j] = 1'b0;
            end
        end

        assign colBits[c] = aAligned & bReg;
    end

endmodule

// ==== verilog/columnCounter.sv ====
`timescale 1ns/1ns

`include "approxMul_defs.svh"

// reduces one matrix column to its registered ones count
module columnCounter (
    input  logic                    clk,
    input  approxMulPkg::colBits_t  bits,
    output approxMulPkg::colCount_t count
);

    import approxMulPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // population count
    ////////////////////////////////////////////////////////////////////////////

    colCount_t ones;
    colBits_t  rest;

    // walk the column one bit at a time
    // synthesis flattens this into an adder tree
    always_comb begin
        rest = bits;
        ones = '0;
        for (int k = 0; k < `AM_WIDTH; k++) begin
            ones = ones + colCount_t'(rest[0]);
            rest = rest >> 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // count register
    ////////////////////////////////////////////////////////////////////////////

    // loaded every cycle, valid travels alongside in the assembler
    always_ff @(posedge clk) begin
        count <= ones;
    end

endmodule

// ==== verilog/productAssembler.sv ====
`timescale 1ns/1ns

`include "approxMul_defs.svh"

// weights the column counts, adds them up and applies the low-byte bias
module productAssembler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ppValid,
    input  approxMulPkg::colCount_t counts [`AM_NUM_COLS],
    output logic                    outValid,
    output logic [`AM_PROD_W-1:0]   product
);

    import approxMulPkg::*;

    // count placed at its column weight in the product word
    function automatic logic [`AM_PROD_W-1:0] weighCount(
        input colCount_t count,
        input int        weight
    );
        return `AM_PROD_W'(count) << weight;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // weighted sum
    ////////////////////////////////////////////////////////////////////////////

    logic [`AM_PROD_W-1:0] weighted   [`AM_NUM_COLS];
    logic [`AM_PROD_W-1:0] partialSum [`AM_NUM_COLS+1];
    logic [`AM_PROD_W-1:0] productNext;
    logic                  validDelay;

    assign partialSum[0] = '0;

    // running sum over the columns, lowest weight first
    for (genvar c = 0; c < `AM_NUM_COLS; c++) begin : gSum
        assign weighted[c]     = weighCount(counts[c], c + `AM_TRUNC_COL);
        assign partialSum[c+1] = partialSum[c] + weighted[c];
    end

    // every kept term sits at weight AM_TRUNC_COL or above,
    // so the low byte is still zero here and the bias can be ORed in
    assign productNext = partialSum[`AM_NUM_COLS] | `AM_PROD_W'(`AM_BIAS);

    ////////////////////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////////////////////

    // ppValid lines up with colBits, the counts arrive one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            validDelay <= 1'b0;
            outValid   <= 1'b0;
        end else begin
            validDelay <= ppValid;
            outValid   <= validDelay;
        end
    end

    // result word
    always_ff @(posedge clk) begin
        product <= productNext;
    end

endmodule

// ==== verilog/approxMul.sv ====
`timescale 1ns/1ns

`include "approxMul_defs.svh"

// pipelined approximate 16x16 unsigned multiplier, three register stages
module approxMul (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,
    input  logic [`AM_WIDTH-1:0]  a,
    input  logic [`AM_WIDTH-1:0]  b,
    output logic                  outValid,
    output logic [`AM_PROD_W-1:0] product
);

    import approxMulPkg::*;

    logic      ppValid;
    colBits_t  colBits [`AM_NUM_COLS];
    colCount_t counts  [`AM_NUM_COLS];

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, operands and matrix
    ////////////////////////////////////////////////////////////////////////////

    ppMatrix matrix0 (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .a       (a),
        .b       (b),
        .ppValid (ppValid),
        .colBits (colBits)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, one counter per kept column
    ////////////////////////////////////////////////////////////////////////////

    for (genvar c = 0; c < `AM_NUM_COLS; c++) begin : gCounter
        columnCounter counter0 (
            .clk   (clk),
            .bits  (colBits[c]),
            .count (counts[c])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 3, final sum
    ////////////////////////////////////////////////////////////////////////////

    productAssembler assembler0 (
        .clk      (clk),
        .rst      (rst),
        .ppValid  (ppValid),
        .counts   (counts),
        .outValid (outValid),
        .product  (product)
    );

endmodule

// ==== testbench/approxMulTb.sv ====
`timescale 1ns/1ns

`include "approxMul_defs.svh"

module approxMulTb;

    // reset plus about 1,100 strobes with gaps, with a wide margin
    localparam int TimeoutCycles = 3000;
    localparam int RandomPairs   = 1000;
    localparam int BurstPairs    = 8;

    logic                  clk;
    logic                  rst;
    logic                  inValid;
    logic [`AM_WIDTH-1:0]  a;
    logic [`AM_WIDTH-1:0]  b;
    logic                  outValid;
    logic [`AM_PROD_W-1:0] product;

    // operand pairs in flight, oldest first
    logic [`AM_WIDTH-1:0] aQ[$];
    logic [`AM_WIDTH-1:0] bQ[$];
    string                nameQ[$];

    // expectation for the result now on the outputs
    logic [`AM_PROD_W-1:0] expProduct;
    logic                  headValid;
    logic                  headZero;
    string                 headName;

    integer seed;
    int     cycleCount;
    int     sentCount;
    int     resultCount;

    approxMul dut0 (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .a        (a),
        .b        (b),
        .outValid (outValid),
        .product  (product)
    );

    ////////////////////////////////////////////////////////////////////////////
    // clock and run limit
    ////////////////////////////////////////////////////////////////////////////

    initial clk = 1'b0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            failRun("timeout, the run did not complete within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    // sum of the kept partial products, then the fixed low-byte bias
    function automatic logic [`AM_PROD_W-1:0] truncatedProduct(
        input logic [`AM_WIDTH-1:0] x,
        input logic [`AM_WIDTH-1:0] y
    );
        logic [`AM_PROD_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < `AM_WIDTH; i++) begin
            for (int j = 0; j < `AM_WIDTH; j++) begin
                if ((i + j >= `AM_TRUNC_COL) && x[i] && y[j]) begin
                    sum = sum + (`AM_PROD_W'(1) << (i + j));
                end
            end
        end
        return sum + `AM_PROD_W'(`AM_BIAS);
    endfunction

    function automatic logic [`AM_WIDTH-1:0] randomOperand();
        return `AM_WIDTH'($random(seed));
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // pops the pair that belongs to a result now on the outputs
    task automatic updateExpected();
        headValid = 1'b0;
        if (outValid && (aQ.size() > 0)) begin
            headZero    = (aQ[0] == '0) || (bQ[0] == '0);
            expProduct  = truncatedProduct(aQ.pop_front(), bQ.pop_front());
            headName    = nameQ.pop_front();
            headValid   = 1'b1;
            resultCount = resultCount + 1;
        end
    endtask

    // one clock, inputs change 1 ns after the edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
        updateExpected();
    endtask

    task automatic sendPair(
        input logic [`AM_WIDTH-1:0] x,
        input logic [`AM_WIDTH-1:0] y,
        input string                name
    );
        stepCycle();
        inValid = 1'b1;
        a       = x;
        b       = y;
        aQ.push_back(x);
        bQ.push_back(y);
        nameQ.push_back(name);
        sentCount = sentCount + 1;
    endtask

    // operands keep moving while idle, the DUT must ignore them
    task automatic idleCycle();
        stepCycle();
        inValid = 1'b0;
        a       = randomOperand();
        b       = randomOperand();
    endtask

    // three pipeline stages, then a couple of quiet cycles
    task automatic drainPipeline();
        repeat (5) idleCycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks, sampled on the falling edge where everything is settled
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(negedge clk) rst |-> !outValid)
        else failRun("output valid was high during reset");

    assert property (@(negedge clk) disable iff (rst) inValid |-> ##3 outValid)
        else failRun("a strobe was not followed by output valid three cycles later");

    assert property (@(negedge clk) disable iff (rst) outValid |-> $past(inValid, 3))
        else failRun("output valid appeared without a strobe three cycles earlier");

    assert property (@(negedge clk) disable iff (rst) outValid |-> headValid)
        else failRun("output valid appeared with no operand pair in flight");

    assert property (@(negedge clk) disable iff (rst)
        outValid && headValid |-> product == expProduct)
        else failRun($sformatf("ERROR test=%s expected=%h actual=%h",
            headName, expProduct, product));

    // a zero operand leaves only the bias
    assert property (@(negedge clk) disable iff (rst)
        outValid && headValid && headZero |-> product == `AM_PROD_W'(`AM_BIAS))
        else failRun($sformatf("ERROR test=%s expected=%h actual=%h",
            headName, `AM_PROD_W'(`AM_BIAS), product));

    assert property (@(negedge clk) disable iff (rst)
        outValid |-> product[7:0] == 8'(`AM_BIAS))
        else failRun($sformatf("ERROR test=%s expected=%h actual=%h",
            headName, 8'(`AM_BIAS), product[7:0]));

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed        = 37;
        rst         = 1'b1;
        inValid     = 1'b0;
        a           = '0;
        b           = '0;
        expProduct  = '0;
        headValid   = 1'b0;
        headZero    = 1'b0;
        headName    = "none";
        cycleCount  = 0;
        sentCount   = 0;
        resultCount = 0;

        repeat (16) stepCycle();
        rst = 1'b0;

        // quiet outputs right after reset
        repeat (6) idleCycle();

        // zero operands
        repeat (4) sendPair('0, randomOperand(), "zeroA");
        repeat (4) sendPair(randomOperand(), '0, "zeroB");
        sendPair('0, '0, "zeroBoth");
        idleCycle();

        // full matrix, then a case that lives only in dropped columns
        sendPair(16'hFFFF, 16'hFFFF, "allOnes");
        idleCycle();
        sendPair(16'h00FF, 16'h0001, "lowColumns");
        repeat (5) idleCycle();

        // three or more in flight
        repeat (BurstPairs) sendPair(randomOperand(), randomOperand(), "burst");
        repeat (5) idleCycle();

        // random pairs, mostly back to back, some gaps
        for (int k = 0; k < RandomPairs; k++) begin
            sendPair(randomOperand(), randomOperand(), "random");
            if (($random(seed) & 3) == 0) begin
                idleCycle();
            end
        end

        drainPipeline();

        if ((aQ.size() == 0) && (resultCount == sentCount)) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            failRun("the number of results does not match the number of strobes");
        end
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/approxMulPkg.sv
verilog/ppMatrix.sv
verilog/columnCounter.sv
verilog/productAssembler.sv
verilog/approxMul.sv
testbench/approxMulTb.sv

// ==== Makefile ====
# Verilator flow for the approximate multiplier

TOP = approxMulTb
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own, then together with the testbench
lint:
	verilator --lint-only --timing --assert -f src.f --top-module approxMul
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

# build and run, pass only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -Mdir $(OBJ)
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ)
